/* dcache_config.svh */
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// log2 of the line size in bytes
`define CACHE_LINE_WIDTH 6

`define TAG_WIDTH 20

// 6 index bits for the default geometry
`define INDEX_WIDTH (32 - `CACHE_LINE_WIDTH - `TAG_WIDTH)

`define NUM_LINES 64

// word offset inside a line
`define OFFSET_WIDTH 4

// byte address bits decoded by the sram, upper bits alias
`define SRAM_ADDR_WIDTH 14

`endif

/* ahb_pkg.sv */
package ahb_pkg;

	typedef enum logic [1:0] {
		htrans_idle   = 2'b00,
		htrans_busy   = 2'b01,
		htrans_nonseq = 2'b10,
		htrans_seq    = 2'b11
	} htrans_t;

	typedef logic [31:0] haddr_t;

	typedef logic [31:0] hdata_t;

	typedef logic [2:0] hburst_t;

	typedef logic [2:0] hsize_t;

	// line fills and evictions are always incr16 of words
	localparam hburst_t hburst_incr16 = 3'b111;

	localparam hsize_t hsize_word = 3'b010;

endpackage

/* dcache_pkg.sv */
`include "dcache_config.svh"

package dcache_pkg;

	typedef logic [31:0] word_t;

	typedef logic [3:0] byte_en_t;

	typedef logic [`TAG_WIDTH-1:0] tag_t;

	typedef logic [`INDEX_WIDTH-1:0] index_t;

	typedef logic [`OFFSET_WIDTH-1:0] offset_t;

	// controller states
	typedef enum logic [2:0] {
		st_idle            = 3'd0,
		st_writeback_first = 3'd1,
		st_writeback       = 3'd2,
		st_memread_first   = 3'd3,
		st_memread         = 3'd4,
		st_wait_write      = 3'd5
	} dcache_state_t;

endpackage

/* cache_line.sv */
`timescale 1ns/1ps

`include "dcache_config.svh"

module cache_line
	import dcache_pkg::*;
(
	input  logic     clk,
	input  logic     nrst,
	input  offset_t  rd_off,
	output tag_t     rd_tag,
	output word_t    rd_data,
	output logic     rd_valid,
	output logic     rd_dirty,
	input  logic     wr_write,
	input  tag_t     wr_tag,
	input  offset_t  wr_off,
	input  word_t    wr_data,
	input  byte_en_t wr_byte_enable,
	input  logic     wr_valid,
	input  logic     wr_dirty
);

	tag_t  tag;
	word_t words [2 ** `OFFSET_WIDTH];

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			rd_valid <= 1'b0;
			rd_dirty <= 1'b0;
		end else if (wr_write) begin
			rd_valid <= wr_valid;
			rd_dirty <= wr_dirty;
		end
	end

	// zero byte enable leaves the data alone
	always_ff @(posedge clk) begin
		if (wr_write) begin
			tag <= wr_tag;
			for (int b = 0; b < $bits(byte_en_t); b++) begin
				if (wr_byte_enable[b]) begin
					words[wr_off][8*b +: 8] <= wr_data[8*b +: 8];
				end
			end
		end
	end

	assign rd_tag  = tag;
	assign rd_data = words[rd_off];

endmodule

/* dcache.sv */
`timescale 1ns/1ps

`include "dcache_config.svh"

module dcache
	import ahb_pkg::*, dcache_pkg::*;
(
	input  logic     clk,
	input  logic     nrst,
	input  haddr_t   dbus_addr,
	input  byte_en_t dbus_byteenable,
	input  logic     dbus_read,
	input  logic     dbus_write,
	input  logic     dbus_hitwriteback,
	input  logic     dbus_hitinvalidate,
	input  word_t    dbus_wrdata,
	output word_t    dbus_rddata,
	output logic     dbus_stall,
	output haddr_t   haddr,
	output htrans_t  htrans,
	output logic     hwrite,
	output hdata_t   hwdata,
	output hburst_t  hburst,
	output hsize_t   hsize,
	output logic     hsel,
	input  hdata_t   hrdata,
	input  logic     hready
);

	dcache_state_t state;

	tag_t    cpu_tag;
	index_t  cpu_idx;
	offset_t cpu_off;

	tag_t    mem_tag;
	index_t  burst_idx;
	// address phase beat
	offset_t mem_off;
	// data phase beat, one behind mem_off during a refill
	offset_t access_off;

	index_t  rd_idx_q;
	offset_t rd_off_q;
	offset_t rd_off;
	index_t  cur_idx;

	tag_t  line_tag   [`NUM_LINES];
	word_t line_data  [`NUM_LINES];
	logic  line_valid [`NUM_LINES];
	logic  line_dirty [`NUM_LINES];

	logic     line_we;
	tag_t     wr_tag;
	offset_t  wr_off;
	word_t    wr_data;
	byte_en_t wr_be;
	logic     wr_valid;
	logic     wr_dirty;

	logic  cl_valid;
	logic  cl_dirty;
	logic  tag_match;
	logic  cl_hit;
	tag_t  cl_tag;
	word_t cl_data;

	logic need_writeback;
	logic need_memread;
	logic need_invalidate;

	for (genvar i = 0; i < `NUM_LINES; i++) begin : g_line
		cache_line u_line (
			.clk            (clk),
			.nrst           (nrst),
			.rd_off         (rd_off),
			.rd_tag         (line_tag[i]),
			.rd_data        (line_data[i]),
			.rd_valid       (line_valid[i]),
			.rd_dirty       (line_dirty[i]),
			.wr_write       (line_we && cur_idx == index_t'(i)),
			.wr_tag         (wr_tag),
			.wr_off         (wr_off),
			.wr_data        (wr_data),
			.wr_byte_enable (wr_be),
			.wr_valid       (wr_valid),
			.wr_dirty       (wr_dirty)
		);
	end

	assign {cpu_tag, cpu_idx, cpu_off} = dbus_addr[31:2];

	// idle serves the cpu, bursts walk the line
	assign cur_idx = (state == st_idle) ? cpu_idx : burst_idx;
	assign rd_off  = (state == st_idle) ? rd_off_q : access_off;

	assign cl_valid  = line_valid[cur_idx];
	assign cl_dirty  = line_dirty[cur_idx];
	assign cl_tag    = line_tag[cur_idx];
	assign cl_data   = line_data[cur_idx];
	assign tag_match = cl_tag == cpu_tag;
	assign cl_hit    = cl_valid && tag_match;

	assign need_writeback = cl_valid && cl_dirty && (
		((dbus_read || dbus_write) && !tag_match) ||
		((dbus_hitwriteback || dbus_hitinvalidate) && tag_match));
	assign need_memread    = (dbus_read || dbus_write) && !cl_hit;
	assign need_invalidate = dbus_hitinvalidate && cl_hit;

	assign dbus_stall  = state != st_idle || need_writeback || need_memread;
	assign dbus_rddata = line_data[rd_idx_q];

	assign haddr  = {mem_tag, burst_idx, mem_off, 2'b00};
	assign hburst = hburst_incr16;
	assign hsize  = hsize_word;

	// read word shows up the cycle after acceptance
	always_ff @(posedge clk) begin
		if (dbus_read && !dbus_stall) begin
			rd_idx_q <= cpu_idx;
			rd_off_q <= cpu_off;
		end
	end

	always_comb begin
		line_we  = 1'b0;
		wr_tag   = cl_tag;
		wr_off   = cpu_off;
		wr_data  = dbus_wrdata;
		wr_be    = '0;
		wr_valid = cl_valid;
		wr_dirty = cl_dirty;
		case (state)
			st_idle: begin
				if (!need_writeback && !need_memread) begin
					if (dbus_write) begin
						line_we  = 1'b1;
						wr_be    = dbus_byteenable;
						wr_valid = 1'b1;
						wr_dirty = 1'b1;
					end else if (need_invalidate) begin
						line_we  = 1'b1;
						wr_valid = 1'b0;
						wr_dirty = 1'b0;
					end
				end
			end
			st_writeback: begin
				// line is clean once the last beat is taken
				if (hready && mem_off == '0) begin
					line_we  = 1'b1;
					wr_dirty = 1'b0;
				end
			end
			st_memread: begin
				if (hready) begin
					line_we  = 1'b1;
					wr_tag   = mem_tag;
					wr_off   = access_off;
					wr_data  = hrdata;
					wr_be    = '1;
					wr_dirty = 1'b0;
					wr_valid = mem_off == '0;
				end
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (hready && (state == st_writeback_first ||
			(state == st_writeback && mem_off != '0))) begin
			hwdata <= cl_data;
		end
	end

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			state      <= st_idle;
			htrans     <= htrans_idle;
			hwrite     <= 1'b0;
			hsel       <= 1'b0;
			mem_tag    <= '0;
			burst_idx  <= '0;
			mem_off    <= '0;
			access_off <= '0;
		end else begin
			case (state)
				st_idle: begin
					if (need_writeback) begin
						// evict under the old tag
						state      <= st_writeback_first;
						mem_tag    <= cl_tag;
						burst_idx  <= cpu_idx;
						mem_off    <= '0;
						access_off <= '0;
						htrans     <= htrans_nonseq;
						hwrite     <= 1'b1;
						hsel       <= 1'b1;
					end else if (need_memread) begin
						state      <= st_memread_first;
						mem_tag    <= cpu_tag;
						burst_idx  <= cpu_idx;
						mem_off    <= '0;
						access_off <= '1;
						htrans     <= htrans_nonseq;
						hwrite     <= 1'b0;
						hsel       <= 1'b1;
					end else if (dbus_write || need_invalidate) begin
						state <= st_wait_write;
					end
				end
				st_writeback_first, st_memread_first: begin
					if (hready) begin
						mem_off    <= mem_off + 1'b1;
						access_off <= access_off + 1'b1;
						htrans     <= htrans_seq;
						if (state == st_writeback_first) begin
							state <= st_writeback;
						end else begin
							state <= st_memread;
						end
					end
				end
				st_writeback, st_memread: begin
					if (hready) begin
						if (mem_off == '0) begin
							hsel   <= 1'b0;
							hwrite <= 1'b0;
							state  <= st_wait_write;
						end else begin
							// beat 16 address phase done
							if (mem_off == '1) begin
								htrans <= htrans_idle;
							end
							mem_off    <= mem_off + 1'b1;
							access_off <= access_off + 1'b1;
						end
					end
				end
				st_wait_write: begin
					state <= st_idle;
				end
				default: begin
					state <= st_idle;
				end
			endcase
		end
	end

endmodule

/* ahb_sram.sv */
`timescale 1ns/1ps

`include "dcache_config.svh"

module ahb_sram
	import ahb_pkg::*;
(
	input  logic    clk,
	input  logic    nrst,
	input  haddr_t  haddr,
	input  htrans_t htrans,
	input  logic    hwrite,
	input  hdata_t  hwdata,
	input  logic    hsel,
	output hdata_t  hrdata,
	output logic    hready
);

	localparam int sram_words = 2 ** (`SRAM_ADDR_WIDTH - 2);

	hdata_t mem [sram_words] = '{default: '0};

	// latched address phase
	logic [`SRAM_ADDR_WIDTH-3:0] addr_q;
	logic                        active_q;
	logic                        write_q;
	logic                        wait_q;

	assign hready = !wait_q;
	assign hrdata = mem[addr_q];

	always_ff @(posedge clk or negedge nrst) begin
		if (!nrst) begin
			active_q <= 1'b0;
			write_q  <= 1'b0;
			wait_q   <= 1'b0;
		end else if (hready) begin
			active_q <= hsel && (htrans == htrans_nonseq || htrans == htrans_seq);
			write_q  <= hwrite;
			// one wait state for every nonseq
			wait_q   <= hsel && htrans == htrans_nonseq;
		end else begin
			wait_q <= 1'b0;
		end
	end

	// write lands when the data phase completes
	always_ff @(posedge clk) begin
		if (hready) begin
			if (active_q && write_q) begin
				mem[addr_q] <= hwdata;
			end
			addr_q <= haddr[`SRAM_ADDR_WIDTH-1:2];
		end
	end

endmodule

/* dcache_subsys.sv */
`timescale 1ns/1ps

module dcache_subsys
	import ahb_pkg::*, dcache_pkg::*;
(
	input  logic     clk,
	input  logic     nrst,
	input  haddr_t   dbus_addr,
	input  byte_en_t dbus_byteenable,
	input  logic     dbus_read,
	input  logic     dbus_write,
	input  logic     dbus_hitwriteback,
	input  logic     dbus_hitinvalidate,
	input  word_t    dbus_wrdata,
	output word_t    dbus_rddata,
	output logic     dbus_stall
);

	// ahb link
	haddr_t  haddr;
	htrans_t htrans;
	logic    hwrite;
	hdata_t  hwdata;
	logic    hsel;
	hdata_t  hrdata;
	logic    hready;

	dcache u_dcache (
		.clk                (clk),
		.nrst               (nrst),
		.dbus_addr          (dbus_addr),
		.dbus_byteenable    (dbus_byteenable),
		.dbus_read          (dbus_read),
		.dbus_write         (dbus_write),
		.dbus_hitwriteback  (dbus_hitwriteback),
		.dbus_hitinvalidate (dbus_hitinvalidate),
		.dbus_wrdata        (dbus_wrdata),
		.dbus_rddata        (dbus_rddata),
		.dbus_stall         (dbus_stall),
		.haddr              (haddr),
		.htrans             (htrans),
		.hwrite             (hwrite),
		.hwdata             (hwdata),
		.hburst             (),
		.hsize              (),
		.hsel               (hsel),
		.hrdata             (hrdata),
		.hready             (hready)
	);

	// burst and size are fixed, the sram ignores them
	ahb_sram u_sram (
		.clk    (clk),
		.nrst   (nrst),
		.haddr  (haddr),
		.htrans (htrans),
		.hwrite (hwrite),
		.hwdata (hwdata),
		.hsel   (hsel),
		.hrdata (hrdata),
		.hready (hready)
	);

endmodule

/* tb_clkgen.sv */
`timescale 1ns/1ps

module tb_clkgen (
	output logic clk,
	output logic nrst
);

	initial begin
		clk  = 1'b0;
		nrst = 1'b0;
		// reset over three rising edges
		repeat (3) @(posedge clk);
		#1 nrst = 1'b1;
	end

	// 10 ns period
	always #5 clk = ~clk;

endmodule

/* dcache_chk.sv */
`timescale 1ns/1ps

module dcache_chk
	import ahb_pkg::*;
(
	input logic    clk,
	input logic    nrst,
	input htrans_t htrans,
	input logic    hready,
	input logic    hsel,
	input logic    dbus_stall
);

	// assertion failures so far
	int fail_count = 0;

	// address phase frozen under a wait state
	htrans_hold: assert property (@(posedge clk) disable iff (!nrst)
		!hready |=> $stable(htrans))
		else begin
			$error("htrans changed while hready was low");
			fail_count++;
		end

	burst_start: assert property (@(posedge clk) disable iff (!nrst)
		$rose(hsel) |-> htrans == htrans_nonseq)
		else begin
			$error("burst did not start with a nonseq transfer");
			fail_count++;
		end

	seq_follows: assert property (@(posedge clk) disable iff (!nrst)
		htrans == htrans_seq |-> $past(htrans) inside {htrans_nonseq, htrans_seq})
		else begin
			$error("seq transfer outside a burst");
			fail_count++;
		end

	hsel_reset: assert property (@(posedge clk)
		$rose(nrst) |-> !hsel)
		else begin
			$error("hsel high right after reset");
			fail_count++;
		end

	// no cpu request can be taken while a burst runs
	busy_stall: assert property (@(posedge clk) disable iff (!nrst)
		hsel |-> dbus_stall)
		else begin
			$error("cpu bus not stalled during a burst");
			fail_count++;
		end

endmodule

bind dcache dcache_chk chk (
	.clk        (clk),
	.nrst       (nrst),
	.htrans     (htrans),
	.hready     (hready),
	.hsel       (hsel),
	.dbus_stall (dbus_stall)
);

/* dcache_tb.sv */
`timescale 1ns/1ps

`include "dcache_config.svh"

module dcache_tb
	import ahb_pkg::*, dcache_pkg::*;
();

	localparam int timeout_cycles = 200;
	localparam int model_words    = 2 ** (`SRAM_ADDR_WIDTH - 2);
	localparam int op_read        = 0;
	localparam int op_write       = 1;
	localparam int op_hitwb       = 2;
	localparam int op_hitinv      = 3;

	logic     clk;
	logic     nrst;
	haddr_t   dbus_addr;
	byte_en_t dbus_byteenable;
	logic     dbus_read;
	logic     dbus_write;
	logic     dbus_hitwriteback;
	logic     dbus_hitinvalidate;
	word_t    dbus_wrdata;
	word_t    dbus_rddata;
	logic     dbus_stall;

	// flat image of what memory should hold
	word_t  model [model_words];
	word_t  exp_q [$];
	haddr_t exp_addr_q [$];

	string cur_test      = "reset";
	int    errors        = 0;
	int    errors_base   = 0;
	int    tests_run     = 0;
	int    tests_failed  = 0;
	int    reads_checked = 0;

	tb_clkgen clkgen (
		.clk  (clk),
		.nrst (nrst)
	);

	dcache_subsys dut (
		.clk                (clk),
		.nrst               (nrst),
		.dbus_addr          (dbus_addr),
		.dbus_byteenable    (dbus_byteenable),
		.dbus_read          (dbus_read),
		.dbus_write         (dbus_write),
		.dbus_hitwriteback  (dbus_hitwriteback),
		.dbus_hitinvalidate (dbus_hitinvalidate),
		.dbus_wrdata        (dbus_wrdata),
		.dbus_rddata        (dbus_rddata),
		.dbus_stall         (dbus_stall)
	);

	function automatic word_t merge_bytes(word_t old, word_t data, byte_en_t be);
		word_t w;
		w = old;
		for (int b = 0; b < 4; b++) begin
			if (be[b]) begin
				w[8*b +: 8] = data[8*b +: 8];
			end
		end
		return w;
	endfunction

	// expected read data from the model
	function automatic word_t ref_read(haddr_t addr);
		return model[addr[`SRAM_ADDR_WIDTH-1:2]];
	endfunction

	task automatic report_value(string what, word_t expected, word_t actual);
		$display("Error: %s %s expected 0x%0h actual 0x%0h", cur_test, what, expected, actual);
		errors++;
	endtask

	task automatic report_problem(string what);
		$display("Error: %s %s", cur_test, what);
		errors++;
	endtask

	task automatic end_run();
		if (dut.u_dcache.chk.fail_count != 0) begin
			$display("Error: %0d protocol assertions failed", dut.u_dcache.chk.fail_count);
			errors += dut.u_dcache.chk.fail_count;
		end
		$display("tests run %0d, tests failed %0d, reads checked %0d, errors %0d",
			tests_run, tests_failed, reads_checked, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	endtask

	task automatic abort_on_timeout(string what);
		$display("Error: %s timed out after %0d cycles waiting for %s",
			cur_test, timeout_cycles, what);
		errors++;
		end_run();
	endtask

	task automatic clear_requests();
		dbus_read          = 1'b0;
		dbus_write         = 1'b0;
		dbus_hitwriteback  = 1'b0;
		dbus_hitinvalidate = 1'b0;
	endtask

	task automatic start_test(string name);
		cur_test    = name;
		errors_base = errors;
	endtask

	task automatic finish_test();
		// last read compare lands on the negedge before this
		@(posedge clk);
		tests_run++;
		if (errors != errors_base) begin
			tests_failed++;
			$display("test %s: %0d errors", cur_test, errors - errors_base);
		end else begin
			$display("test %s: ok", cur_test);
		end
	endtask

	// hold one cpu request until taken and wait for the controller to go idle
	task automatic issue(input int op, input haddr_t addr, input word_t data,
			input byte_en_t be, output int stalled, output int busy_after);
		@(posedge clk);
		#1;
		dbus_addr          = addr;
		dbus_wrdata        = data;
		dbus_byteenable    = be;
		dbus_read          = op == op_read;
		dbus_write         = op == op_write;
		dbus_hitwriteback  = op == op_hitwb;
		dbus_hitinvalidate = op == op_hitinv;
		stalled = 0;
		@(negedge clk);
		while (dbus_stall) begin
			if (stalled == timeout_cycles) begin
				abort_on_timeout("request acceptance");
			end
			stalled++;
			@(negedge clk);
		end
		// taken on this edge
		@(posedge clk);
		#1;
		if (op == op_read) begin
			exp_q.push_back(ref_read(addr));
			exp_addr_q.push_back(addr);
		end else if (op == op_write) begin
			model[addr[`SRAM_ADDR_WIDTH-1:2]] = merge_bytes(ref_read(addr), data, be);
		end
		clear_requests();
		busy_after = 0;
		@(negedge clk);
		while (dbus_stall) begin
			if (busy_after == timeout_cycles) begin
				abort_on_timeout("controller idle");
			end
			busy_after++;
			@(negedge clk);
		end
	endtask

	// read data is valid the cycle after acceptance
	always @(negedge clk) begin : compare_reads
		word_t  exp_word;
		haddr_t exp_addr;
		if (exp_q.size() != 0) begin
			exp_word = exp_q.pop_front();
			exp_addr = exp_addr_q.pop_front();
			reads_checked++;
			if (dbus_rddata !== exp_word) begin
				$display("Error: %s read 0x%08h expected 0x%08h actual 0x%08h",
					cur_test, exp_addr, exp_word, dbus_rddata);
				errors++;
			end
		end
	end

	task automatic test_cold_miss();
		int stalled;
		int busy;
		start_test("cold_read_miss");
		issue(op_read, 32'h0000_0104, '0, '0, stalled, busy);
		if (stalled == 0) begin
			report_problem("first read after reset did not stall");
		end
		issue(op_read, 32'h0000_0138, '0, '0, stalled, busy);
		if (stalled != 0) begin
			report_value("stall cycles on a line hit", 0, stalled);
		end
		finish_test();
	endtask

	task automatic test_write_hit();
		int       stalled;
		int       busy;
		haddr_t   addr;
		byte_en_t be;
		start_test("write_hit_byte_enable");
		for (int i = 0; i < 16; i++) begin
			addr = 32'h0000_0100 + 4 * ($urandom % 16);
			be   = byte_en_t'($urandom);
			issue(op_write, addr, $urandom, be, stalled, busy);
			if (stalled != 0) begin
				report_value("stall cycles before a write hit", 0, stalled);
			end
			if (busy != 1) begin
				report_value("stall cycles after a write hit", 1, busy);
			end
			issue(op_read, addr, '0, '0, stalled, busy);
		end
		finish_test();
	endtask

	task automatic test_eviction();
		int     stalled;
		int     busy;
		haddr_t base;
		base = 32'h0000_0240;
		start_test("eviction_writeback");
		// words 0, 5, 10 and 15
		for (int i = 0; i < 4; i++) begin
			issue(op_write, base + 20 * i, $urandom, 4'hf, stalled, busy);
		end
		issue(op_read, base ^ 32'h1000, '0, '0, stalled, busy);
		if (stalled == 0) begin
			report_problem("conflicting read did not miss");
		end
		for (int i = 0; i < 4; i++) begin
			issue(op_read, base + 20 * i, '0, '0, stalled, busy);
		end
		finish_test();
	endtask

	task automatic test_hit_writeback();
		int     stalled;
		int     busy;
		haddr_t base;
		base = 32'h0000_03c8;
		start_test("hit_writeback");
		issue(op_write, base, $urandom, 4'hf, stalled, busy);
		issue(op_hitwb, base, '0, '0, stalled, busy);
		if (stalled == 0) begin
			report_problem("hit-writeback of a dirty line did not stall");
		end
		issue(op_hitwb, base, '0, '0, stalled, busy);
		if (stalled != 0) begin
			report_value("stall cycles for hit-writeback of a clean line", 0, stalled);
		end
		issue(op_read, base ^ 32'h1000, '0, '0, stalled, busy);
		issue(op_read, base ^ 32'h2000, '0, '0, stalled, busy);
		issue(op_read, base, '0, '0, stalled, busy);
		finish_test();
	endtask

	task automatic test_hit_invalidate();
		int     stalled;
		int     busy;
		haddr_t base;
		base = 32'h0000_0514;
		start_test("hit_invalidate");
		issue(op_write, base, $urandom, 4'hf, stalled, busy);
		issue(op_hitinv, base, '0, '0, stalled, busy);
		if (stalled == 0) begin
			report_problem("invalidate of a dirty line did not write it back");
		end
		if (busy != 1) begin
			report_value("stall cycles after an invalidate", 1, busy);
		end
		issue(op_read, base, '0, '0, stalled, busy);
		if (stalled == 0) begin
			report_problem("read after invalidate did not miss");
		end
		finish_test();
	endtask

	task automatic test_random_mix();
		int     stalled;
		int     busy;
		int     pick;
		int     op;
		haddr_t addr;
		start_test("random_mix");
		for (int i = 0; i < 300; i++) begin
			// two indices with four aliasing tags
			addr = {18'h0, 2'($urandom % 4), 6'(2 + $urandom % 2), 4'($urandom % 16), 2'b00};
			pick = $urandom % 10;
			if (pick < 4) begin
				op = op_read;
			end else if (pick < 8) begin
				op = op_write;
			end else if (pick == 8) begin
				op = op_hitwb;
			end else begin
				op = op_hitinv;
			end
			issue(op, addr, $urandom, byte_en_t'($urandom), stalled, busy);
		end
		finish_test();
	endtask

	initial begin
		int unsigned seed;
		int          cycles;
		seed = 32'hde42_9193;
		void'($urandom(seed));
		dbus_addr       = '0;
		dbus_wrdata     = '0;
		dbus_byteenable = '0;
		clear_requests();
		foreach (model[i]) begin
			model[i] = '0;
		end
		cycles = 0;
		while (nrst !== 1'b1) begin
			if (cycles == timeout_cycles) begin
				abort_on_timeout("reset release");
			end
			cycles++;
			@(posedge clk);
		end
		test_cold_miss();
		test_write_hit();
		test_eviction();
		test_hit_writeback();
		test_hit_invalidate();
		test_random_mix();
		if (exp_q.size() != 0) begin
			report_problem("reads were left without a compare");
		end
		end_run();
	end

endmodule

/* files.f */
+incdir+.
ahb_pkg.sv
dcache_pkg.sv
cache_line.sv
dcache.sv
ahb_sram.sv
dcache_subsys.sv
tb_clkgen.sv
dcache_chk.sv
dcache_tb.sv
